//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_mem_wb
FLIST     ?= sources.f
BUILD     ?= obj_dir
VFLAGS    ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD)

//--- alu_exec.sv
`timescale 1ns/10ps

module alu_exec
(
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::ex_mem_t o_ex
);
    import mips_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;

    assign op_a = i_id_ex.rs_val;
    // Immediate replaces rt for I-type
    assign op_b = i_id_ex.alu_src ? i_id_ex.imm : i_id_ex.rt_val;

    always_comb
    begin
        case (i_id_ex.alu_op)
            ALU_ADD:
                result = op_a + op_b;
            ALU_SUB:
                result = op_a - op_b;
            ALU_AND:
                result = op_a & op_b;
            ALU_OR:
                result = op_a | op_b;
            ALU_XOR:
                result = op_a ^ op_b;
            ALU_NOR:
                result = ~(op_a | op_b);
            ALU_SLT:
                result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:
                result = {{(XLEN-1){1'b0}}, op_a < op_b};
            // Shifts act on operand B by shamt
            ALU_SLL:
                result = op_b << i_id_ex.shamt;
            ALU_SRL:
                result = op_b >> i_id_ex.shamt;
            ALU_SRA:
                result = $unsigned($signed(op_b) >>> i_id_ex.shamt);
            default:
                result = '0;
        endcase
    end

    always_comb
    begin
        o_ex.pc8        = i_id_ex.pc8;
        o_ex.br_target  = i_id_ex.pc4 + (i_id_ex.imm << 2);
        o_ex.alu_result = result;
        // Branch compare is on rs and rt, not on the ALU output
        o_ex.zero       = (i_id_ex.rs_val == i_id_ex.rt_val);
        o_ex.store_data = i_id_ex.rt_val;
        o_ex.rd         = i_id_ex.rd;
        o_ex.imm16      = i_id_ex.imm[15:0];
        o_ex.branch     = i_id_ex.branch;
        o_ex.nbranch    = i_id_ex.nbranch;
        o_ex.mem_write  = i_id_ex.mem_write;
        o_ex.mem_read   = i_id_ex.mem_read;
        o_ex.store_size = i_id_ex.store_size;
        o_ex.wb         = i_id_ex.wb;
    end

endmodule

//--- ex_mem_wb_props.sv
`timescale 1ns/10ps

module ex_mem_wb_props
(
    input logic       i_clk,
    input logic       i_reset,
    input logic       i_flush,
    input logic       o_branch_taken,
    input logic       o_reg_we,
    input logic [4:0] o_reg_addr,
    input logic       o_halt
);

    // Both pipeline registers hold bubbles in reset
    assert property (@(posedge i_clk) i_reset |-> !o_reg_we && !o_branch_taken && !o_halt)
        else $error("control output high during reset");

    assert property (@(posedge i_clk) disable iff (i_reset) i_flush |=> !o_branch_taken)
        else $error("branch taken after flush");

    assert property (@(posedge i_clk) disable iff (i_reset) o_reg_we |-> o_reg_addr != 5'd0)
        else $error("write to register 0");

endmodule

bind ex_mem_wb_top ex_mem_wb_props ex_mem_wb_props_inst (.*);

//--- ex_mem_wb_top.sv
`timescale 1ns/10ps

module ex_mem_wb_top
#(
    parameter int MEM_DEPTH = 256
)
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_flush,
    input  mips_pkg::id_ex_t            i_id_ex,
    output logic                        o_branch_taken,
    output logic [mips_pkg::XLEN-1:0]   o_branch_target,
    output logic                        o_reg_we,
    output logic [mips_pkg::REG_AW-1:0] o_reg_addr,
    output logic [mips_pkg::XLEN-1:0]   o_reg_wdata,
    output logic                        o_halt
);
    import mips_pkg::*;

    ex_mem_t ex_d;
    ex_mem_t ex_q;
    mem_wb_t mem_d;
    mem_wb_t mem_q;

    alu_exec alu_exec_inst
    (
        .i_id_ex (i_id_ex),
        .o_ex    (ex_d)
    );

    // Flush squashes the instruction leaving execute
    pipe_reg #(.T_PAYLOAD(ex_mem_t)) ex_mem_reg
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_d     (ex_d),
        .o_q     (ex_q)
    );

    mem_stage #(.MEM_DEPTH(MEM_DEPTH)) mem_stage_inst
    (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_ex            (ex_q),
        .o_mem           (mem_d),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target)
    );

    pipe_reg #(.T_PAYLOAD(mem_wb_t)) mem_wb_reg
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (1'b0),
        .i_d     (mem_d),
        .o_q     (mem_q)
    );

    wb_stage wb_stage_inst
    (
        .i_mem       (mem_q),
        .o_reg_we    (o_reg_we),
        .o_reg_addr  (o_reg_addr),
        .o_reg_wdata (o_reg_wdata),
        .o_halt      (o_halt)
    );

endmodule

//--- mem_stage.sv
`timescale 1ns/10ps

module mem_stage
#(
    parameter int MEM_DEPTH = 256
)
(
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  mips_pkg::ex_mem_t         i_ex,
    output mips_pkg::mem_wb_t         o_mem,
    output logic                      o_branch_taken,
    output logic [mips_pkg::XLEN-1:0] o_branch_target
);
    import mips_pkg::*;

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    logic [XLEN-1:0]  mem [MEM_DEPTH];
    logic [XLEN-1:0]  word_addr;
    logic [IDX_W-1:0] idx;
    logic [1:0]       off;

    // Word address wraps at the memory depth
    assign word_addr = i_ex.alu_result >> 2;
    assign idx       = IDX_W'(word_addr % MEM_DEPTH);
    assign off       = i_ex.alu_result[1:0];

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < MEM_DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (i_ex.mem_write)
        begin
            case (i_ex.store_size)
                SZ_BYTE:
                    mem[idx][{off, 3'b000} +: 8] <= i_ex.store_data[7:0];
                SZ_HALF:
                    mem[idx][{off[1], 4'b0000} +: 16] <= i_ex.store_data[15:0];
                default:
                    mem[idx] <= i_ex.store_data;
            endcase
        end
    end

    // beq on equal, bne on not equal
    assign o_branch_taken  = (i_ex.branch & i_ex.zero) | (i_ex.nbranch & ~i_ex.zero);
    assign o_branch_target = i_ex.br_target;

    always_comb
    begin
        o_mem.pc8        = i_ex.pc8;
        o_mem.alu_result = i_ex.alu_result;
        // Read happens before this cycle's store lands
        o_mem.load_word  = i_ex.mem_read ? mem[idx] : '0;
        o_mem.lui_val    = {i_ex.imm16, 16'h0000};
        o_mem.rd         = i_ex.rd;
        o_mem.wb         = i_ex.wb;
    end

endmodule

//--- mips_pkg.sv
package mips_pkg;

    // Datapath widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef enum logic [3:0]
    {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0]
    {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    // Writeback controls, carried through every stage
    typedef struct packed
    {
        logic      jal;
        logic      mem_to_reg;
        logic      reg_write;
        mem_size_e load_size;
        logic      zero_extend;
        logic      lui;
        logic      halt;
    } wb_ctrl_t;

    // Decoded instruction entering execute
    typedef struct packed
    {
        logic [XLEN-1:0]   pc4;
        logic [XLEN-1:0]   pc8;
        logic [XLEN-1:0]   rs_val;
        logic [XLEN-1:0]   rt_val;
        logic [XLEN-1:0]   imm;
        logic [4:0]        shamt;
        logic [REG_AW-1:0] rd;
        alu_op_e           alu_op;
        logic              alu_src;
        logic              branch;
        logic              nbranch;
        logic              mem_write;
        logic              mem_read;
        mem_size_e         store_size;
        wb_ctrl_t          wb;
    } id_ex_t;

    typedef struct packed
    {
        logic [XLEN-1:0]   pc8;
        logic [XLEN-1:0]   br_target;
        logic [XLEN-1:0]   alu_result;
        logic              zero;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
        logic [15:0]       imm16;
        logic              branch;
        logic              nbranch;
        logic              mem_write;
        logic              mem_read;
        mem_size_e         store_size;
        wb_ctrl_t          wb;
    } ex_mem_t;

    typedef struct packed
    {
        logic [XLEN-1:0]   pc8;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   load_word;
        logic [XLEN-1:0]   lui_val;
        logic [REG_AW-1:0] rd;
        wb_ctrl_t          wb;
    } mem_wb_t;

endpackage

//--- pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg
#(
    parameter type T_PAYLOAD = logic
)
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_flush,
    input  T_PAYLOAD i_d,
    output T_PAYLOAD o_q
);

    // All-zero payload is a bubble
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
            o_q <= '0;
        else if (i_flush)
            o_q <= '0;
        else
            o_q <= i_d;
    end

endmodule

//--- sources.f
mips_pkg.sv
alu_exec.sv
pipe_reg.sv
mem_stage.sv
wb_stage.sv
ex_mem_wb_top.sv
ex_mem_wb_props.sv
tb_ex_mem_wb.sv

//--- tb_ex_mem_wb.sv
`timescale 1ns/10ps

module tb_ex_mem_wb;
    import mips_pkg::*;

    localparam int MEM_DEPTH = 256;
    localparam int RESET_CYCLES = 16;
    localparam int N_INSTR = 110;

    typedef struct
    {
        int              due;
        string           name;
        logic            taken;
        logic [XLEN-1:0] target;
        logic            we;
        logic [4:0]      addr;
        logic [XLEN-1:0] wdata;
        logic            halt;
    } exp_t;

    logic                i_clk;
    logic                i_reset;
    logic                i_flush;
    id_ex_t              i_id_ex;
    logic                o_branch_taken;
    logic [XLEN-1:0]     o_branch_target;
    logic                o_reg_we;
    logic [REG_AW-1:0]   o_reg_addr;
    logic [XLEN-1:0]     o_reg_wdata;
    logic                o_halt;

    logic [31:0]         lfsr = 32'h516b_0b8d;
    logic [XLEN-1:0]     model_mem [MEM_DEPTH];
    int                  cyc = 0;
    exp_t                br_q[$];
    exp_t                wb_q[$];

    ex_mem_wb_top #(.MEM_DEPTH(MEM_DEPTH)) ex_mem_wb_top_inst
    (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_flush         (i_flush),
        .i_id_ex         (i_id_ex),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_reg_we        (o_reg_we),
        .o_reg_addr      (o_reg_addr),
        .o_reg_wdata     (o_reg_wdata),
        .o_halt          (o_halt)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #4 i_clk = ~i_clk;
        end
    end

    always @(posedge i_clk)
    begin
        cyc <= cyc + 1;
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input id_ex_t ins);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = ins.rs_val;
        b = ins.alu_src ? ins.imm : ins.rt_val;
        case (ins.alu_op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return (a | b) & ~(a & b);
            ALU_NOR:  return ~a & ~b;
            ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLTU: return {31'd0, a < b};
            ALU_SLL:  return b << ins.shamt;
            ALU_SRL:  return b >> ins.shamt;
            ALU_SRA:  return (b >> ins.shamt) | (b[31] ? ~(32'hFFFF_FFFF >> ins.shamt) : 32'h0);
            default:  return '0;
        endcase
    endfunction

    function automatic exp_t reference(input id_ex_t ins);
        exp_t            e;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] w;
        logic [XLEN-1:0] ld;
        logic            eq;
        res = alu_model(ins);
        eq = (ins.rs_val == ins.rt_val);
        e.taken = (ins.branch && eq) || (ins.nbranch && !eq);
        e.target = ins.pc4 + {ins.imm[29:0], 2'b00};
        w = ins.mem_read ? model_mem[int'((res >> 2) % MEM_DEPTH)] : '0;
        if (ins.wb.load_size == SZ_BYTE)
        begin
            ld = (w >> (8 * res[1:0])) & 32'hFF;
            if (!ins.wb.zero_extend && ld[7])
                ld = ld | 32'hFFFF_FF00;
        end
        else if (ins.wb.load_size == SZ_HALF)
        begin
            ld = (w >> (16 * res[1])) & 32'hFFFF;
            if (!ins.wb.zero_extend && ld[15])
                ld = ld | 32'hFFFF_0000;
        end
        else
            ld = w;
        if (ins.wb.jal)
            e.wdata = ins.pc8;
        else if (ins.wb.lui)
            e.wdata = {ins.imm[15:0], 16'h0};
        else if (ins.wb.mem_to_reg)
            e.wdata = ld;
        else
            e.wdata = res;
        e.we = ins.wb.reg_write && (ins.rd != 0);
        e.addr = ins.rd;
        e.halt = ins.wb.halt;
        return e;
    endfunction

    function automatic void apply_store(input id_ex_t ins);
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] mask;
        int              idx;
        addr = alu_model(ins);
        idx = int'((addr >> 2) % MEM_DEPTH);
        if (ins.store_size == SZ_BYTE)
            mask = 32'hFF << (8 * addr[1:0]);
        else if (ins.store_size == SZ_HALF)
            mask = 32'hFFFF << (16 * addr[1]);
        else
            mask = 32'hFFFF_FFFF;
        model_mem[idx] = (model_mem[idx] & ~mask) | ((ins.rt_val << (8 * addr[1:0])) & mask);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Input lands in EX/MEM at the next edge, outputs follow one and two cycles later
    task automatic issue(input id_ex_t ins, input logic flush, input string name);
        exp_t e;
        @(posedge i_clk);
        if (!flush)
        begin
            e = reference(ins);
            e.name = name;
            e.due = cyc + 2;
            br_q.push_back(e);
            e.due = cyc + 3;
            wb_q.push_back(e);
            if (ins.mem_write)
                apply_store(ins);
        end
        i_id_ex <= ins;
        i_flush <= flush;
    endtask

    function automatic id_ex_t mem_ins(input int base, input logic [1:0] off,
                                       input mem_size_e size, input logic store,
                                       input logic zx);
        id_ex_t ins;
        ins = '0;
        ins.alu_op = ALU_ADD;
        ins.alu_src = 1'b1;
        ins.rs_val = base << 2;
        ins.imm = {30'd0, off};
        ins.rt_val = rand_bits(32);
        ins.mem_write = store;
        ins.store_size = size;
        ins.mem_read = !store;
        ins.rd = 5'd1 + 5'(rand_bits(5) % 31);
        ins.wb.mem_to_reg = !store;
        ins.wb.reg_write = !store;
        ins.wb.load_size = size;
        ins.wb.zero_extend = zx;
        return ins;
    endfunction

    // Compare process, outputs are settled at the falling edge
    initial
    begin
        exp_t e;
        wait (i_reset == 1'b0);
        forever
        begin
            @(negedge i_clk);
            if (br_q.size() != 0 && br_q[0].due == cyc)
            begin
                e = br_q.pop_front();
                check({e.name, " taken"}, 32'(e.taken), 32'(o_branch_taken));
                if (e.taken)
                    check({e.name, " target"}, e.target, o_branch_target);
            end
            else
                check("idle branch", 0, 32'(o_branch_taken));
            if (wb_q.size() != 0 && wb_q[0].due == cyc)
            begin
                e = wb_q.pop_front();
                check({e.name, " we"}, 32'(e.we), 32'(o_reg_we));
                check({e.name, " halt"}, 32'(e.halt), 32'(o_halt));
                if (e.we)
                begin
                    check({e.name, " addr"}, 32'(e.addr), 32'(o_reg_addr));
                    check({e.name, " wdata"}, e.wdata, o_reg_wdata);
                end
            end
            else
            begin
                check("idle we", 0, 32'(o_reg_we));
                check("idle halt", 0, 32'(o_halt));
            end
        end
    end

    initial
    begin
        #((RESET_CYCLES + N_INSTR + 40) * 8);
        $display("Watchdog expired before the tests finished");
        $display("Errors found");
        $fatal(1);
    end

    initial
    begin
        id_ex_t      ins;
        int          base;
        logic [15:0] imm16;
        i_reset = 1'b1;
        i_flush = 1'b0;
        i_id_ex = '0;
        for (int i = 0; i < MEM_DEPTH; i++)
            model_mem[i] = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (4) issue('0, 1'b0, "after_reset");
        for (int k = 0; k < 40; k++)
        begin
            ins = '0;
            ins.alu_op = alu_op_e'(rand_bits(4) % 11);
            ins.alu_src = 1'(rand_bits(1));
            ins.rs_val = rand_bits(32);
            ins.rt_val = rand_bits(32);
            ins.imm = rand_bits(32);
            ins.shamt = 5'(rand_bits(5));
            ins.rd = (k % 8 == 0) ? 5'd0 : 5'(rand_bits(5));
            ins.wb.reg_write = 1'b1;
            issue(ins, 1'b0, "alu");
        end
        for (int k = 0; k < 8; k++)
        begin
            base = int'(rand_bits(8));
            issue(mem_ins(base,
                          (k % 3 == 0) ? 2'(rand_bits(2)) :
                          (k % 3 == 1) ? {1'(rand_bits(1)), 1'b0} : 2'b00,
                          mem_size_e'(k % 3), 1'b1, 1'b0), 1'b0, "store");
            issue(mem_ins(base, 2'b00, SZ_WORD, 1'b0, 1'b0), 1'b0, "load_word");
            issue(mem_ins(base, {1'(rand_bits(1)), 1'b0}, SZ_HALF, 1'b0, 1'b0), 1'b0,
                  "load_half");
            issue(mem_ins(base, {1'(rand_bits(1)), 1'b0}, SZ_HALF, 1'b0, 1'b1), 1'b0,
                  "load_halfu");
            issue(mem_ins(base, 2'(rand_bits(2)), SZ_BYTE, 1'b0, 1'b0), 1'b0, "load_byte");
            issue(mem_ins(base, 2'(rand_bits(2)), SZ_BYTE, 1'b0, 1'b1), 1'b0, "load_byteu");
        end
        for (int k = 0; k < 8; k++)
        begin
            ins = '0;
            ins.pc4 = rand_bits(32);
            ins.pc8 = ins.pc4 + 4;
            ins.rs_val = rand_bits(32);
            ins.rt_val = k[0] ? ins.rs_val : ins.rs_val ^ (rand_bits(32) | 32'h1);
            imm16 = 16'(rand_bits(16));
            ins.imm = {{16{imm16[15]}}, imm16};
            ins.branch = !k[1];
            ins.nbranch = k[1];
            issue(ins, 1'b0, k[1] ? "bne" : "beq");
        end
        ins = '0;
        ins.pc4 = rand_bits(32);
        ins.pc8 = ins.pc4 + 4;
        ins.rd = 5'd31;
        ins.wb.jal = 1'b1;
        ins.wb.reg_write = 1'b1;
        issue(ins, 1'b0, "jal");
        ins = '0;
        imm16 = 16'(rand_bits(16));
        ins.imm = {{16{imm16[15]}}, imm16};
        ins.rd = 5'd9;
        ins.wb.lui = 1'b1;
        ins.wb.reg_write = 1'b1;
        issue(ins, 1'b0, "lui");
        ins = '0;
        ins.wb.halt = 1'b1;
        issue(ins, 1'b0, "halt");
        // Flushed store and branch leave no trace
        ins = '0;
        ins.rs_val = rand_bits(32);
        ins.rd = 5'd5;
        ins.wb.reg_write = 1'b1;
        issue(ins, 1'b0, "before_flush");
        ins = mem_ins(3, 2'b00, SZ_WORD, 1'b1, 1'b0);
        ins.branch = 1'b1;
        ins.nbranch = 1'b1;
        ins.rd = 5'd6;
        ins.wb.reg_write = 1'b1;
        issue(ins, 1'b1, "flushed");
        issue(mem_ins(3, 2'b00, SZ_WORD, 1'b0, 1'b0), 1'b0, "load_after_flush");
        repeat (4) issue('0, 1'b0, "drain");
        // Last writeback is due three cycles after the final issue
        repeat (4) @(negedge i_clk);
        if (br_q.size() != 0 || wb_q.size() != 0)
        begin
            $display("Expected results were left unchecked at the end of the run");
            $display("Errors found");
            $fatal(1);
        end
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- wb_stage.sv
`timescale 1ns/10ps

module wb_stage
(
    input  mips_pkg::mem_wb_t           i_mem,
    output logic                        o_reg_we,
    output logic [mips_pkg::REG_AW-1:0] o_reg_addr,
    output logic [mips_pkg::XLEN-1:0]   o_reg_wdata,
    output logic                        o_halt
);
    import mips_pkg::*;

    logic [1:0]      off;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] ld_data;

    assign off     = i_mem.alu_result[1:0];
    assign ld_byte = i_mem.load_word[{off, 3'b000} +: 8];
    assign ld_half = i_mem.load_word[{off[1], 4'b0000} +: 16];

    always_comb
    begin
        case (i_mem.wb.load_size)
            SZ_BYTE:
                ld_data = {{(XLEN-8){ld_byte[7] & ~i_mem.wb.zero_extend}}, ld_byte};
            SZ_HALF:
                ld_data = {{(XLEN-16){ld_half[15] & ~i_mem.wb.zero_extend}}, ld_half};
            default:
                ld_data = i_mem.load_word;
        endcase
    end

    // Link address wins over everything else
    assign o_reg_wdata = i_mem.wb.jal        ? i_mem.pc8 :
                         i_mem.wb.lui        ? i_mem.lui_val :
                         i_mem.wb.mem_to_reg ? ld_data : i_mem.alu_result;

    assign o_reg_we   = i_mem.wb.reg_write & (i_mem.rd != '0);
    assign o_reg_addr = i_mem.rd;
    assign o_halt     = i_mem.wb.halt;

endmodule
